/* Makefile */
SRCS := $(filter-out +%,$(shell cat tb.f))

obj_dir/Vmycpu_tb: tb.f $(SRCS)
	verilator --binary --timing --assert --top-module mycpu_tb -f tb.f -o Vmycpu_tb

run: obj_dir/Vmycpu_tb
	./obj_dir/Vmycpu_tb

clean:
	rm -rf obj_dir

.PHONY: run clean

/* src/common.sv */
// common types, enums and helpers shared by the multicycle core
package common;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  creg_addr_t;

    // supported operations
    typedef enum logic [3:0] {
        op_addiu,
        op_addu,
        op_subu,
        op_and,
        op_or,
        op_lui,
        op_lw,
        op_sw,
        op_beq,
        op_invalid
    } op_t;

    typedef struct packed {
        op_t          op;
        creg_addr_t   rs;
        creg_addr_t   rt;
        creg_addr_t   dst;
        logic [15:0]  imm;
    } decoded_t;

    // core sequencing
    typedef enum logic [1:0] {
        s_fetch,
        s_execute,
        s_memory,
        s_writeback
    } cpu_state_t;

    // per-port bus handshake
    typedef enum logic [1:0] {
        hs_idle,
        hs_wait_addr,
        hs_wait_data
    } hs_state_t;

    localparam word_t reset_pc = 32'hbfc0_0000;

    // kseg0/kseg1 fold onto the low physical range
    function automatic word_t translate_addr(input word_t vaddr);
        word_t paddr;
        paddr = vaddr;
        case (vaddr[31:28])
            4'h8, 4'h9, 4'ha, 4'hb: paddr[31:29] = 3'b000;
            default: paddr = vaddr;
        endcase
        return paddr;
    endfunction

endpackage

/* src/datapath.sv */
// multicycle datapath with control FSM, register file, alu and retire record
module datapath import common::*; (
    input  logic       clk,
    input  logic       reset,
    input  word_t      instr,
    input  logic       i_data_ok,
    input  logic       d_data_ok,
    input  word_t      rd,
    output word_t      pc,
    output logic       i_req,
    output logic       rf_wen,
    output creg_addr_t rf_wnum,
    output word_t      rf_wdata,
    output word_t      wb_pc,
    dmem_if.master     dmem
);
    cpu_state_t state;
    cpu_state_t state_next;
    word_t      ir;
    decoded_t   dec;
    word_t      regs [32];
    word_t      rs_val;
    word_t      rt_val;
    word_t      imm_sext;
    word_t      pc_plus4;
    word_t      alu_out;
    word_t      result_q;
    word_t      next_pc_q;
    logic       wb_wen;
    logic       is_mem;

    decoder u_decoder (
        .instr (ir),
        .dec   (dec)
    );

    // register 0 is hardwired to zero
    assign rs_val = (dec.rs == '0) ? '0 : regs[dec.rs];
    assign rt_val = (dec.rt == '0) ? '0 : regs[dec.rt];

    assign imm_sext = {{16{dec.imm[15]}}, dec.imm};
    assign pc_plus4 = pc + 32'd4;
    assign is_mem   = (dec.op == op_lw) || (dec.op == op_sw);

    always_comb begin
        case (dec.op)
            op_addiu, op_lw, op_sw: alu_out = rs_val + imm_sext;
            op_addu: alu_out = rs_val + rt_val;
            op_subu: alu_out = rs_val - rt_val;
            op_and:  alu_out = rs_val & rt_val;
            op_or:   alu_out = rs_val | rt_val;
            op_lui:  alu_out = {dec.imm, 16'h0000};
            default: alu_out = '0;
        endcase
    end

    always_comb begin
        case (dec.op)
            op_addiu, op_addu, op_subu, op_and, op_or, op_lui, op_lw: wb_wen = 1'b1;
            default: wb_wen = 1'b0;
        endcase
    end

    always_comb begin
        state_next = state;
        case (state)
            s_fetch: begin
                if (i_data_ok) begin
                    state_next = s_execute;
                end
            end
            s_execute: state_next = is_mem ? s_memory : s_writeback;
            s_memory: begin
                if (d_data_ok) begin
                    state_next = s_writeback;
                end
            end
            s_writeback: state_next = s_fetch;
            default: state_next = s_fetch;
        endcase
    end

    // data request held for the whole memory state
    assign dmem.ren  = (state == s_memory) && (dec.op == op_lw);
    assign dmem.wen  = (state == s_memory) && (dec.op == op_sw);
    assign dmem.addr = result_q;
    assign dmem.wd   = rt_val;

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= s_fetch;
            i_req  <= 1'b0;
            pc     <= reset_pc;
            rf_wen <= 1'b0;
            wb_pc  <= '0;
        end else begin
            state  <= state_next;
            // fetch request raised on entry, dropped after completion
            i_req  <= (state_next == s_fetch);
            rf_wen <= (state == s_writeback) && wb_wen;
            if (state == s_writeback) begin
                pc    <= next_pc_q;
                wb_pc <= pc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == s_fetch && i_data_ok) begin
            ir <= instr;
        end
        if (state == s_execute) begin
            result_q <= alu_out;
            // beq target relative to the following instruction
            if (dec.op == op_beq && rs_val == rt_val) begin
                next_pc_q <= pc_plus4 + (imm_sext << 2);
            end else begin
                next_pc_q <= pc_plus4;
            end
        end
        if (state == s_memory && d_data_ok && dmem.ren) begin
            result_q <= rd;
        end
        if (state == s_writeback) begin
            rf_wnum  <= dec.dst;
            rf_wdata <= result_q;
        end
    end

    // register file
    always_ff @(posedge clk) begin
        if (state == s_writeback && wb_wen) begin
            regs[dec.dst] <= result_q;
        end
    end

    // data completions only arrive while the memory state waits for them
    assert property (@(posedge clk) disable iff (reset)
        d_data_ok |-> state == s_memory);

endmodule

/* src/decoder.sv */
// instruction decoder for the supported MIPS subset
module decoder import common::*; (
    input  word_t    instr,
    output decoded_t dec
);
    logic [5:0] opcode;
    logic [5:0] funct;
    op_t        op;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];

    assign dec.op  = op;
    assign dec.rs  = instr[25:21];
    assign dec.rt  = instr[20:16];
    assign dec.imm = instr[15:0];

    always_comb begin
        op = op_invalid;
        case (opcode)
            6'b000000: begin
                // special group, selected by funct
                case (funct)
                    6'b100001: op = op_addu;
                    6'b100011: op = op_subu;
                    6'b100100: op = op_and;
                    6'b100101: op = op_or;
                    default:   op = op_invalid;
                endcase
            end
            6'b001001: op = op_addiu;
            6'b001111: op = op_lui;
            6'b100011: op = op_lw;
            6'b101011: op = op_sw;
            6'b000100: op = op_beq;
            default:   op = op_invalid;
        endcase
    end

    // register forms write rd, everything else writes rt
    always_comb begin
        case (op)
            op_addu, op_subu, op_and, op_or: dec.dst = instr[15:11];
            default: dec.dst = instr[20:16];
        endcase
    end

endmodule

/* src/dmem_if.sv */
// data memory request bundle between the datapath and the bus wrapper
interface dmem_if import common::*; ();

    logic  ren;
    logic  wen;
    word_t addr;
    word_t wd;

    modport master (
        output ren,
        output wen,
        output addr,
        output wd
    );

    modport slave (
        input ren,
        input wen,
        input addr,
        input wd
    );

endinterface

/* src/handshake.sv */
// bus handshake FSM turning a held cpu request into req and a completion pulse
module handshake import common::*; (
    input  logic clk,
    input  logic reset,
    input  logic cpu_req,
    input  logic addr_ok,
    input  logic data_ok,
    output logic req,
    output logic cpu_data_ok
);
    hs_state_t state;
    hs_state_t state_next;

    // request passes through until the address is taken
    assign req = (state != hs_wait_data) && cpu_req;
    assign cpu_data_ok = (state == hs_wait_data) && data_ok;

    always_comb begin
        state_next = state;
        case (state)
            hs_idle: begin
                if (req && addr_ok) begin
                    state_next = hs_wait_data;
                end else if (req) begin
                    state_next = hs_wait_addr;
                end
            end
            hs_wait_addr: begin
                if (addr_ok) begin
                    state_next = hs_wait_data;
                end
            end
            hs_wait_data: begin
                if (data_ok) begin
                    state_next = hs_idle;
                end
            end
            default: state_next = hs_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= hs_idle;
        end else begin
            state <= state_next;
        end
    end

    // the slave answers only what was accepted
    assert property (@(posedge clk) disable iff (reset) state == hs_idle |-> !data_ok);

    // the cpu keeps its request up until the completion pulse
    assert property (@(posedge clk) disable iff (reset) state != hs_idle |-> cpu_req);

endmodule

/* src/mycpu.sv */
// core top level with sram-style bus ports, address translation and debug trace
module mycpu import common::*; #(
    parameter logic do_addr_translation = 1'b1
) (
    input  logic       clk,
    input  logic       reset,

    output logic       inst_req,
    output word_t      inst_addr,
    input  word_t      inst_rdata,
    input  logic       inst_addr_ok,
    input  logic       inst_data_ok,

    output logic       data_req,
    output logic       data_wr,
    output word_t      data_addr,
    output word_t      data_wdata,
    input  word_t      data_rdata,
    input  logic       data_addr_ok,
    input  logic       data_data_ok,

    // debug
    output word_t      debug_wb_pc,
    output logic [3:0] debug_wb_rf_wen,
    output creg_addr_t debug_wb_rf_wnum,
    output word_t      debug_wb_rf_wdata
);
    word_t pc;
    logic  i_req;
    logic  i_data_ok;
    logic  d_data_ok;
    logic  rf_wen;

    dmem_if dmem ();

    datapath u_datapath (
        .clk       (clk),
        .reset     (reset),
        .instr     (inst_rdata),
        .i_data_ok (i_data_ok),
        .d_data_ok (d_data_ok),
        .rd        (data_rdata),
        .pc        (pc),
        .i_req     (i_req),
        .rf_wen    (rf_wen),
        .rf_wnum   (debug_wb_rf_wnum),
        .rf_wdata  (debug_wb_rf_wdata),
        .wb_pc     (debug_wb_pc),
        .dmem      (dmem.master)
    );

    handshake i_handshake (
        .clk         (clk),
        .reset       (reset),
        .cpu_req     (i_req),
        .addr_ok     (inst_addr_ok),
        .data_ok     (inst_data_ok),
        .req         (inst_req),
        .cpu_data_ok (i_data_ok)
    );

    handshake d_handshake (
        .clk         (clk),
        .reset       (reset),
        .cpu_req     (dmem.ren | dmem.wen),
        .addr_ok     (data_addr_ok),
        .data_ok     (data_data_ok),
        .req         (data_req),
        .cpu_data_ok (d_data_ok)
    );

    // both ports share the segment mapping
    assign inst_addr  = do_addr_translation ? translate_addr(pc) : pc;
    assign data_addr  = do_addr_translation ? translate_addr(dmem.addr) : dmem.addr;
    assign data_wr    = dmem.wen;
    assign data_wdata = dmem.wd;

    // writes to register 0 are not reported
    assign debug_wb_rf_wen = {4{rf_wen && (debug_wb_rf_wnum != '0)}};

    // a pending fetch keeps its address and never overlaps a data request
    assert property (@(posedge clk) disable iff (reset)
        inst_req && !inst_addr_ok |=> inst_req && $stable(inst_addr) && !data_req);

    assert property (@(posedge clk) disable iff (reset)
        data_req && !data_addr_ok |=> data_req && $stable(data_addr) && $stable(data_wr));

endmodule

/* tb.f */
src/common.sv
src/dmem_if.sv
src/handshake.sv
src/decoder.sv
src/datapath.sv
src/mycpu.sv
test/sram_model.sv
test/mycpu_tb.sv

/* test/mycpu_tb.sv */
// testbench for the multicycle core running a short program against a golden retire trace
module mycpu_tb import common::*; ();

    typedef struct packed {
        word_t      pc;
        logic [3:0] wen;
        creg_addr_t wnum;
        word_t      wdata;
    } retire_t;

    typedef struct packed {
        logic  wr;
        word_t addr;
        word_t wdata;
    } dtxn_t;

    localparam int n_words = 19;
    // two bus transactions of up to 8 cycles plus 3 core cycles per instruction, with margin
    localparam int timeout_cycles = 16 + 5 * n_words * (2 * 8 + 3);

    logic             clk;
    logic             reset;
    logic             reset_d;
    logic [1:0]       addr_ok;
    logic [1:0]       data_ok;
    logic [1:0][31:0] rdata;
    logic             bus_error;
    logic             inst_req;
    logic             data_req;
    logic             data_wr;
    word_t            inst_addr;
    word_t            data_addr;
    word_t            data_wdata;
    word_t            debug_wb_pc;
    logic [3:0]       debug_wb_rf_wen;
    creg_addr_t       debug_wb_rf_wnum;
    word_t            debug_wb_rf_wdata;
    word_t            program_words [n_words];
    retire_t          trace [$];
    dtxn_t            dtxns [$];
    retire_t          exp_r;
    dtxn_t            exp_d;
    word_t            last_pc;
    logic             failed;
    int               cycles;
    int               retired;
    int               fetches;
    int               data_txns;

    mycpu #(
        .do_addr_translation (1'b1)
    ) u_mycpu (
        .clk               (clk),
        .reset             (reset),
        .inst_req          (inst_req),
        .inst_addr         (inst_addr),
        .inst_rdata        (rdata[0]),
        .inst_addr_ok      (addr_ok[0]),
        .inst_data_ok      (data_ok[0]),
        .data_req          (data_req),
        .data_wr           (data_wr),
        .data_addr         (data_addr),
        .data_wdata        (data_wdata),
        .data_rdata        (rdata[1]),
        .data_addr_ok      (addr_ok[1]),
        .data_data_ok      (data_ok[1]),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    sram_model u_sram (
        .clk       (clk),
        .reset     (reset),
        .req       ({data_req, inst_req}),
        .wr        ({data_wr, 1'b0}),
        .addr      ({data_addr, inst_addr}),
        .wdata     ({data_wdata, 32'h0}),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .bus_error (bus_error)
    );

    always #5 clk = ~clk;

    task automatic log_mismatch(input string name, input word_t expected, input word_t actual);
        $display("FAILED %s: expected %h, actual %h", name, expected, actual);
        failed = 1'b1;
    endtask

    task automatic raise_error(input string what);
        $display("error: %s", what);
        failed = 1'b1;
    endtask

    // register 0 writes retire with the enable low
    task automatic expect_retire(input word_t pc_offset, input logic writes,
                                 input creg_addr_t wnum, input word_t wdata);
        retire_t r;
        r.pc    = reset_pc + pc_offset;
        r.wen   = (writes && wnum != 5'd0) ? 4'hf : 4'h0;
        r.wnum  = wnum;
        r.wdata = wdata;
        trace.push_back(r);
    endtask

    task automatic queue_data_txn(input logic wr, input word_t addr, input word_t wdata);
        dtxn_t d;
        d.wr    = wr;
        d.addr  = addr;
        d.wdata = wdata;
        dtxns.push_back(d);
    endtask

    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        reset_d   = 1'b1;
        failed    = 1'b0;
        cycles    = 0;
        retired   = 0;
        fetches   = 0;
        data_txns = 0;
        last_pc   = '0;
        program_words = '{
            32'h3c01a000,  // lui   $1, 0xa000
            32'h24021237,  // addiu $2, $0, 0x1237
            32'h2403fffc,  // addiu $3, $0, -4
            32'h00432021,  // addu  $4, $2, $3
            32'h00432823,  // subu  $5, $2, $3
            32'h00433024,  // and   $6, $2, $3
            32'h00433825,  // or    $7, $2, $3
            32'hac240100,  // sw    $4, 0x100($1)
            32'h3c088000,  // lui   $8, 0x8000
            32'h8d090100,  // lw    $9, 0x100($8)
            32'h24000055,  // addiu $0, $0, 0x55
            32'h11240002,  // beq   $9, $4, +2 (taken)
            32'h240a0001,  // addiu $10, $0, 1 (skipped)
            32'h240a0002,  // addiu $10, $0, 2 (skipped)
            32'h240a0003,  // addiu $10, $0, 3
            32'h11420001,  // beq   $10, $2, +1 (not taken)
            32'h254b0010,  // addiu $11, $10, 0x10
            32'h01696021,  // addu  $12, $11, $9
            32'h1000ffff   // beq   $0, $0, -1 (parks the core)
        };
        for (int i = 0; i < n_words; i++) begin
            u_sram.mem[32'h1fc0_0000 + 32'(4 * i)] = program_words[i];
        end
        expect_retire(32'h00, 1'b1, 5'd1, 32'ha000_0000);
        expect_retire(32'h04, 1'b1, 5'd2, 32'h0000_1237);
        expect_retire(32'h08, 1'b1, 5'd3, 32'hffff_fffc);
        expect_retire(32'h0c, 1'b1, 5'd4, 32'h0000_1233);
        expect_retire(32'h10, 1'b1, 5'd5, 32'h0000_123b);
        expect_retire(32'h14, 1'b1, 5'd6, 32'h0000_1234);
        expect_retire(32'h18, 1'b1, 5'd7, 32'hffff_ffff);
        expect_retire(32'h1c, 1'b0, 5'd0, 32'h0);
        expect_retire(32'h20, 1'b1, 5'd8, 32'h8000_0000);
        expect_retire(32'h24, 1'b1, 5'd9, 32'h0000_1233);
        expect_retire(32'h28, 1'b1, 5'd0, 32'h0000_0055);
        expect_retire(32'h2c, 1'b0, 5'd0, 32'h0);
        expect_retire(32'h38, 1'b1, 5'd10, 32'h0000_0003);
        expect_retire(32'h3c, 1'b0, 5'd0, 32'h0);
        expect_retire(32'h40, 1'b1, 5'd11, 32'h0000_0013);
        expect_retire(32'h44, 1'b1, 5'd12, 32'h0000_1246);
        expect_retire(32'h48, 1'b0, 5'd0, 32'h0);
        // both segment aliases land on physical 0x100
        queue_data_txn(1'b1, 32'h0000_0100, 32'h0000_1233);
        queue_data_txn(1'b0, 32'h0000_0100, 32'h0);
        repeat (16) @(posedge clk);
        reset <= 1'b0;
    end

    always @(posedge clk) begin
        if (cycles > 0 && (reset || reset_d)) begin
            assert ({inst_req, data_req, data_wr, debug_wb_rf_wen} == 7'd0)
                else log_mismatch("reset outputs", 32'h0,
                                  32'({inst_req, data_req, data_wr, debug_wb_rf_wen}));
        end
        assert (!bus_error) else raise_error("bus model saw a handshake violation");

        if (!reset && inst_req && addr_ok[0]) begin
            if (fetches == 0) begin
                assert (inst_addr == 32'h1fc0_0000)
                    else log_mismatch("first fetch address", 32'h1fc0_0000, inst_addr);
            end
            assert (inst_addr[31:29] == 3'b000)
                else log_mismatch("fetch address segment", {3'b000, inst_addr[28:0]}, inst_addr);
            fetches = fetches + 1;
        end

        if (!reset && data_req && addr_ok[1]) begin
            if (data_txns >= dtxns.size()) begin
                raise_error("data port saw more transactions than the program makes");
            end else begin
                exp_d = dtxns[data_txns];
                assert (data_wr == exp_d.wr)
                    else log_mismatch("data write flag", 32'(exp_d.wr), 32'(data_wr));
                assert (data_addr == exp_d.addr)
                    else log_mismatch("data address", exp_d.addr, data_addr);
                if (exp_d.wr) begin
                    assert (data_wdata == exp_d.wdata)
                        else log_mismatch("store data", exp_d.wdata, data_wdata);
                end
                data_txns = data_txns + 1;
            end
        end

        // a new retire record shows up as a change of the retired pc
        if (!reset && debug_wb_pc != last_pc) begin
            if (retired >= trace.size()) begin
                raise_error("core retired past the end of the expected trace");
            end else begin
                exp_r = trace[retired];
                assert (debug_wb_pc == exp_r.pc)
                    else log_mismatch("retire pc", exp_r.pc, debug_wb_pc);
                assert (debug_wb_rf_wen == exp_r.wen)
                    else log_mismatch("retire wen", 32'(exp_r.wen), 32'(debug_wb_rf_wen));
                if (exp_r.wen != 4'h0) begin
                    assert (debug_wb_rf_wnum == exp_r.wnum)
                        else log_mismatch("retire wnum", 32'(exp_r.wnum), 32'(debug_wb_rf_wnum));
                    assert (debug_wb_rf_wdata == exp_r.wdata)
                        else log_mismatch("retire wdata", exp_r.wdata, debug_wb_rf_wdata);
                end
                retired = retired + 1;
            end
        end
        last_pc = debug_wb_pc;
        reset_d = reset;
        cycles  = cycles + 1;

        if (cycles >= timeout_cycles) begin
            $display("timeout: program did not finish");
            failed = 1'b1;
        end
        if (failed) begin
            $display("Test failed");
            $fatal(1);
        end else if (retired == trace.size() && data_txns == dtxns.size()) begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule

/* test/sram_model.sv */
// word memory serving the instruction and data bus ports with random handshake delays
module sram_model import common::*; (
    input  logic             clk,
    input  logic             reset,
    input  logic [1:0]       req,
    input  logic [1:0]       wr,
    input  logic [1:0][31:0] addr,
    input  logic [1:0][31:0] wdata,
    output logic [1:0]       addr_ok,
    output logic [1:0]       data_ok,
    output logic [1:0][31:0] rdata,
    output logic             bus_error
);
    localparam logic [1:0] ph_addr   = 2'd0;
    localparam logic [1:0] ph_accept = 2'd1;
    localparam logic [1:0] ph_data   = 2'd2;

    // keyed by word-aligned physical address
    word_t      mem [word_t];
    logic [1:0] port_error;

    assign bus_error = |port_error;

    // port 0 is the instruction side, port 1 the data side
    for (genvar p = 0; p < 2; p++) begin : g_port
        integer     seed = 60;
        logic [1:0] phase = ph_addr;
        logic [1:0] wait_cnt = 2'd0;
        logic       ok_q = 1'b0;
        logic       done_q = 1'b0;
        word_t      rdata_q = '0;
        logic       err_q = 1'b0;
        logic       req_q = 1'b0;
        word_t      addr_q = '0;
        word_t      acc_addr = '0;

        assign addr_ok[p]    = ok_q;
        assign data_ok[p]    = done_q;
        assign rdata[p]      = rdata_q;
        assign port_error[p] = err_q;

        always @(posedge clk) begin
            if (reset) begin
                phase    <= ph_addr;
                wait_cnt <= 2'($random(seed));
                ok_q     <= 1'b0;
                done_q   <= 1'b0;
                req_q    <= 1'b0;
            end else begin
                req_q  <= req[p];
                addr_q <= addr[p];
                done_q <= 1'b0;
                // pending request must stay up with the same address
                if (phase != ph_data && req_q && (!req[p] || addr[p] != addr_q)) begin
                    $display("bus rule broken on port %0d: request dropped or moved", p);
                    err_q <= 1'b1;
                end
                if (phase == ph_data && req[p]) begin
                    $display("bus rule broken on port %0d: new request before data_ok", p);
                    err_q <= 1'b1;
                end
                case (phase)
                    ph_addr: begin
                        if (req[p] && wait_cnt == 2'd0) begin
                            ok_q  <= 1'b1;
                            phase <= ph_accept;
                        end else if (req[p]) begin
                            wait_cnt <= wait_cnt - 2'd1;
                        end
                    end
                    ph_accept: begin
                        ok_q     <= 1'b0;
                        acc_addr <= {addr[p][31:2], 2'b00};
                        wait_cnt <= 2'($random(seed));
                        phase    <= ph_data;
                        if (wr[p]) begin
                            mem[{addr[p][31:2], 2'b00}] = wdata[p];
                        end
                    end
                    default: begin
                        if (wait_cnt == 2'd0) begin
                            done_q   <= 1'b1;
                            rdata_q  <= mem.exists(acc_addr) ? mem[acc_addr] : '0;
                            wait_cnt <= 2'($random(seed));
                            phase    <= ph_addr;
                        end else begin
                            wait_cnt <= wait_cnt - 2'd1;
                        end
                    end
                endcase
            end
        end
    end

endmodule
